//--- files.f
+incdir+include
verilog/ooo_pkg.sv
verilog/dispatch_unit.sv
verilog/reservation_station.sv
verilog/alu_unit.sv
verilog/ooo_core.sv
tests/tb_ooo_core.sv

//--- include/ooo_params.svh
// Widths and depths shared by every block of the issue slice
// The station depth must be a power of two from 2 to 16 and stay below
// the number of rename tags, so that live tags never collide
`ifndef OOO_PARAMS_SVH
`define OOO_PARAMS_SVH

// Operand and result width in bits
`define OOO_DATA_W   32

// Rename tag width, which gives 16 tags
`define OOO_TAG_W    4

// Number of architectural registers
`define OOO_NUM_REGS 8

// Default number of reservation station slots
`define OOO_RS_DEPTH 8

`endif

//--- run.sh
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_ooo_core -f files.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vtb_ooo_core)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "TB PASSED"; then
    exit 0
fi
echo "Pass line not found in simulation output"
exit 1

//--- tests/tb_ooo_core.sv
// Self-checking testbench for the issue slice, driven only through the top level
// The ISA has no immediates and registers reset to zero
// Result values therefore stay zero, and tags, order, latency, hold and flush carry the checks
// Every wait loop has its own cycle limit
`default_nettype none

`include "ooo_params.svh"

module tb_ooo_core;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_TAGS  = 1 << `OOO_TAG_W;
    localparam int WAIT_MAX  = 200;

    logic               clk;
    logic               n_rst;
    logic               i_flush;
    logic               i_hold;
    logic               i_insn_valid;
    ooo_pkg::insn_t     i_insn;
    ooo_pkg::reg_idx_t  i_rd_addr;
    logic               o_stall;
    ooo_pkg::cdb_t      o_cdb;
    ooo_pkg::data_t     o_rd_data;

    // Program-order model of the register file and of every tag in flight
    ooo_pkg::data_t     mregs   [`OOO_NUM_REGS];
    ooo_pkg::data_t     saved   [`OOO_NUM_REGS];
    ooo_pkg::data_t     exp_val [NUM_TAGS];
    logic               pending [NUM_TAGS];
    int                 acc_cyc [NUM_TAGS];
    int                 lat     [NUM_TAGS];
    ooo_pkg::tag_t      mtag;
    ooo_pkg::tag_t      first;
    ooo_pkg::tag_t      tag_log [$];
    int                 outstanding;
    int                 pulse_cnt;
    int                 base;
    int                 cyc;
    int                 val_errs;
    int                 other_errs;
    string              test_name;

    ooo_core dut0 (
        .clk          (clk),
        .n_rst        (n_rst),
        .i_flush      (i_flush),
        .i_hold       (i_hold),
        .i_insn_valid (i_insn_valid),
        .i_insn       (i_insn),
        .i_rd_addr    (i_rd_addr),
        .o_stall      (o_stall),
        .o_cdb        (o_cdb),
        .o_rd_data    (o_rd_data)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    // Expected ALU result per opcode
    function automatic ooo_pkg::data_t alu_ref(input ooo_pkg::opcode_t op,
                                               input ooo_pkg::data_t a,
                                               input ooo_pkg::data_t b);
        case (op)
            ooo_pkg::OP_ADD: return a + b;
            ooo_pkg::OP_SUB: return a - b;
            ooo_pkg::OP_AND: return a & b;
            ooo_pkg::OP_OR:  return a | b;
            ooo_pkg::OP_XOR: return a ^ b;
            ooo_pkg::OP_SLL: return a << b[4:0];
            default:         return '0;
        endcase
    endfunction

    // CDB pulses are sampled mid-cycle, where the bus is stable
    always @(negedge clk) begin
        if (n_rst && o_cdb.valid) begin
            pulse_cnt++;
            tag_log.push_back(o_cdb.tag);
            assert (pending[o_cdb.tag]) else begin
                other_errs++;
                $display("%s: CDB pulse for tag %0d, which is not in flight", test_name, o_cdb.tag);
            end
            if (pending[o_cdb.tag]) begin
                assert (o_cdb.data == exp_val[o_cdb.tag]) else begin
                    val_errs++;
                    $display("FAIL %s: tag %0d expected %h actual %h", test_name, o_cdb.tag,
                             exp_val[o_cdb.tag], o_cdb.data);
                end
                pending[o_cdb.tag] = 1'b0;
                lat[o_cdb.tag]     = cyc - acc_cyc[o_cdb.tag];
                outstanding--;
            end
        end
    end

    // Called at posedge plus 1 ns, returns there once the instruction is accepted
    task automatic send_insn(input ooo_pkg::opcode_t op, input int rd, input int rs1,
                             input int rs2);
        int waited;
        waited          = 0;
        i_insn_valid    = 1'b1;
        i_insn.opcode   = op;
        i_insn.rd       = ooo_pkg::reg_idx_t'(rd);
        i_insn.rs1      = ooo_pkg::reg_idx_t'(rs1);
        i_insn.rs2      = ooo_pkg::reg_idx_t'(rs2);
        @(negedge clk);
        while (o_stall && waited < WAIT_MAX) begin
            @(negedge clk);
            waited++;
        end
        assert (!o_stall) else begin
            other_errs++;
            $display("%s: o_stall never dropped, instruction not accepted", test_name);
        end
        if (!o_stall) begin
            // Accepted at the coming edge, so the model takes it in program order
            exp_val[mtag] = alu_ref(op, mregs[rs1], mregs[rs2]);
            mregs[rd]     = exp_val[mtag];
            pending[mtag] = 1'b1;
            acc_cyc[mtag] = cyc;
            outstanding++;
            mtag = mtag + 1'b1;
        end
        @(posedge clk);
        #1;
        i_insn_valid = 1'b0;
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (outstanding != 0 && waited < WAIT_MAX) begin
            @(posedge clk);
            waited++;
        end
        #1;
        assert (outstanding == 0) else begin
            other_errs++;
            $display("%s: timed out with %0d results missing on the CDB", test_name, outstanding);
        end
    endtask

    task automatic check_regs();
        for (int r = 0; r < `OOO_NUM_REGS; r++) begin
            i_rd_addr = ooo_pkg::reg_idx_t'(r);
            @(negedge clk);
            assert (o_rd_data == mregs[r]) else begin
                val_errs++;
                $display("FAIL %s: r%0d expected %h actual %h", test_name, r, mregs[r], o_rd_data);
            end
            @(posedge clk);
            #1;
        end
    endtask

    // Hold drops together with the flush, so the ALU must drop the issue of that cycle
    task automatic flush_all();
        i_flush = 1'b1;
        i_hold  = 1'b0;
        @(posedge clk);
        #1;
        i_flush = 1'b0;
        mregs   = saved;
        for (int t = 0; t < NUM_TAGS; t++) begin
            pending[t] = 1'b0;
        end
        outstanding = 0;
    endtask

    initial begin
        void'($urandom(32'h1f19));
        n_rst = 1'b0;
        i_flush = 1'b0;
        i_hold = 1'b0;
        i_insn_valid = 1'b0;
        i_insn = '0;
        i_rd_addr = '0;
        {cyc, outstanding, pulse_cnt, val_errs, other_errs} = '0;
        mtag = '0;
        test_name = "reset";
        for (int t = 0; t < NUM_TAGS; t++) begin
            pending[t] = 1'b0;
        end
        for (int r = 0; r < `OOO_NUM_REGS; r++) begin
            mregs[r] = '0;
        end
        repeat (2) @(posedge clk);
        #1;
        n_rst = 1'b1;
        @(negedge clk);
        assert (!o_stall && !o_cdb.valid) else begin
            other_errs++;
            $display("reset: o_stall or o_cdb.valid is high after reset");
        end
        @(posedge clk);
        #1;
        check_regs();

        // The first result must appear two cycles after its accepting edge
        test_name = "independent";
        base = pulse_cnt;
        first = mtag;
        send_insn(ooo_pkg::OP_ADD, 1, 0, 0);
        wait_drain();
        assert (lat[first] == 2) else begin
            val_errs++;
            $display("FAIL %s: latency expected 2 actual %0d", test_name, lat[first]);
        end
        for (int k = 0; k < 4; k++) begin
            send_insn(ooo_pkg::opcode_t'(k), 2 + k, k % 2, 1);
        end
        wait_drain();
        assert (pulse_cnt == base + 5) else begin
            val_errs++;
            $display("FAIL %s: pulses expected %0d actual %0d", test_name, 5, pulse_cnt - base);
        end

        // Each instruction reads the one before, covering every opcode
        test_name = "chain";
        for (int k = 0; k < 6; k++) begin
            send_insn(ooo_pkg::opcode_t'(k), 1 + k % 2, 1 + (k + 1) % 2, 1);
        end
        wait_drain();
        check_regs();

        test_name = "random";
        for (int k = 0; k < 64; k++) begin
            send_insn(ooo_pkg::opcode_t'((k < 6) ? k : $urandom_range(5)),
                      $urandom_range(7), $urandom_range(7), $urandom_range(7));
        end
        wait_drain();
        check_regs();

        // Under hold the station fills and stall rises exactly at full
        test_name = "hold";
        i_hold = 1'b1;
        base = pulse_cnt;
        first = mtag;
        for (int k = 0; k < `OOO_RS_DEPTH; k++) begin
            send_insn(ooo_pkg::OP_OR, 4 + k % 4, k % 4, (k + 1) % 4);
            @(negedge clk);
            assert (o_stall == (k == `OOO_RS_DEPTH - 1)) else begin
                val_errs++;
                $display("FAIL %s: o_stall after %0d accepted expected %0b actual %0b",
                         test_name, k + 1, (k == `OOO_RS_DEPTH - 1), o_stall);
            end
            @(posedge clk);
            #1;
        end
        assert (pulse_cnt == base) else begin
            other_errs++;
            $display("hold: a CDB pulse occurred while issue was held");
        end
        tag_log.delete();
        i_hold = 1'b0;
        wait_drain();
        // Independent entries leave in acceptance order
        for (int k = 0; k < tag_log.size(); k++) begin
            assert (tag_log[k] == ooo_pkg::tag_t'(first + k)) else begin
                val_errs++;
                $display("FAIL %s: tag expected %0d actual %0d", test_name,
                         ooo_pkg::tag_t'(first + k), tag_log[k]);
            end
        end
        check_regs();

        test_name = "flush";
        saved = mregs;
        i_hold = 1'b1;
        send_insn(ooo_pkg::OP_ADD, 1, 2, 3);
        send_insn(ooo_pkg::OP_XOR, 2, 1, 1);
        send_insn(ooo_pkg::OP_SLL, 3, 4, 5);
        flush_all();
        base = pulse_cnt;
        repeat (8) @(posedge clk);
        #1;
        assert (pulse_cnt == base) else begin
            other_errs++;
            $display("flush: CDB pulses arrived after the flush");
        end
        check_regs();

        // Tags continue from the counter across the flush
        test_name = "after flush";
        send_insn(ooo_pkg::OP_SUB, 1, 2, 3);
        send_insn(ooo_pkg::OP_AND, 2, 1, 0);
        send_insn(ooo_pkg::OP_SLL, 3, 2, 1);
        wait_drain();
        check_regs();

        $display("Errors: %0d value mismatches, %0d other failures", val_errs, other_errs);
        if (val_errs == 0 && other_errs == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/alu_unit.sv
// Single-cycle integer ALU whose result register drives the CDB
// There is no stall, every issued operation appears one cycle later
// Flush drops the operation issued in the flush cycle
`default_nettype none

module alu_unit (
    input  wire               clk,
    input  wire               n_rst,
    input  wire               i_flush,
    input  wire               i_issue_valid,
    input  ooo_pkg::issue_t   i_issue,
    output ooo_pkg::cdb_t     o_cdb
);

    ooo_pkg::data_t  result;
    ooo_pkg::data_t  data_q;
    ooo_pkg::tag_t   tag_q;
    logic            valid_q;

    // Operation decode
    always_comb begin
        case (i_issue.opcode)
            ooo_pkg::OP_ADD: result = i_issue.src_a + i_issue.src_b;
            ooo_pkg::OP_SUB: result = i_issue.src_a - i_issue.src_b;
            ooo_pkg::OP_AND: result = i_issue.src_a & i_issue.src_b;
            ooo_pkg::OP_OR:  result = i_issue.src_a | i_issue.src_b;
            ooo_pkg::OP_XOR: result = i_issue.src_a ^ i_issue.src_b;
            // Shift amount is the low 5 bits of source b
            ooo_pkg::OP_SLL: result = i_issue.src_a << i_issue.src_b[4:0];
            default:         result = '0;
        endcase
    end

    // The valid bit is the only control state here
    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= i_issue_valid && !i_flush;
        end
    end

    // Result and tag only load on an issue
    always_ff @(posedge clk) begin
        if (i_issue_valid) begin
            data_q <= result;
            tag_q  <= i_issue.dst_tag;
        end
    end

    assign o_cdb.valid = valid_q;
    assign o_cdb.tag   = tag_q;
    assign o_cdb.data  = data_q;

    // A station slot holding garbage would show up here as an undefined opcode
    a_opcode_defined: assert property (
        @(posedge clk) disable iff (!n_rst)
        i_issue_valid |-> (i_issue.opcode inside {ooo_pkg::OP_ADD, ooo_pkg::OP_SUB,
                                                  ooo_pkg::OP_AND, ooo_pkg::OP_OR,
                                                  ooo_pkg::OP_XOR, ooo_pkg::OP_SLL})
    ) else $error("issued opcode is not a defined operation");

endmodule

`default_nettype wire

//--- verilog/dispatch_unit.sv
// In-order dispatch with register renaming over a rolling tag counter
// Results are written to the register file straight from the CDB
// The caller must hold its instruction while o_stall is high
`default_nettype none

`include "ooo_params.svh"

module dispatch_unit (
    input  wire                 clk,
    input  wire                 n_rst,
    input  wire                 i_flush,
    input  wire                 i_insn_valid,
    input  ooo_pkg::insn_t      i_insn,
    input  wire                 i_full,
    input  ooo_pkg::cdb_t       i_cdb,
    input  ooo_pkg::reg_idx_t   i_rd_addr,
    output logic                o_stall,
    output logic                o_disp_valid,
    output ooo_pkg::rs_entry_t  o_disp,
    output ooo_pkg::data_t      o_rd_data
);

    // Register status table with one value, busy bit and producer tag per register
    ooo_pkg::data_t              reg_val_q [`OOO_NUM_REGS];
    ooo_pkg::tag_t               reg_tag_q [`OOO_NUM_REGS];
    logic [`OOO_NUM_REGS-1:0]    reg_busy_q;

    // Next tag to hand out, it only moves on an accepted instruction
    ooo_pkg::tag_t               next_tag_q;

    // Source register numbers, index 0 feeds operand a
    ooo_pkg::reg_idx_t           src_idx [2];

    logic                        accept;

    // Stall follows the station full level and nothing else
    assign o_stall      = i_full;
    assign accept       = i_insn_valid && !i_full;
    assign o_disp_valid = accept;

    assign src_idx[0]   = i_insn.rs1;
    assign src_idx[1]   = i_insn.rs2;

    // Build the station entry from the status table
    // A result on the CDB this cycle is bypassed so the entry never misses it
    always_comb begin
        o_disp.opcode  = i_insn.opcode;
        o_disp.dst_tag = next_tag_q;
        for (int k = 0; k < 2; k++) begin
            o_disp.src[k].tag = reg_tag_q[src_idx[k]];
            if (!reg_busy_q[src_idx[k]]) begin
                o_disp.src[k].data  = reg_val_q[src_idx[k]];
                o_disp.src[k].ready = 1'b1;
            end else if (i_cdb.valid && (i_cdb.tag == reg_tag_q[src_idx[k]])) begin
                o_disp.src[k].data  = i_cdb.data;
                o_disp.src[k].ready = 1'b1;
            end else begin
                // Still waiting, the station wakes it on the matching pulse
                o_disp.src[k].data  = '0;
                o_disp.src[k].ready = 1'b0;
            end
        end
    end

    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            reg_busy_q <= '0;
            next_tag_q <= '0;
            for (int r = 0; r < `OOO_NUM_REGS; r++) begin
                reg_val_q[r] <= '0;
                reg_tag_q[r] <= '0;
            end
        end else begin
            // Write back any register whose pending producer just broadcast
            for (int r = 0; r < `OOO_NUM_REGS; r++) begin
                if (i_cdb.valid && reg_busy_q[r] && (reg_tag_q[r] == i_cdb.tag)) begin
                    reg_val_q[r]  <= i_cdb.data;
                    reg_busy_q[r] <= 1'b0;
                end
            end
            // Flush forgets every in-flight producer but keeps written values
            // A rename in the same cycle wins over the write back above
            if (i_flush) begin
                reg_busy_q <= '0;
            end else if (accept) begin
                reg_busy_q[i_insn.rd] <= 1'b1;
                reg_tag_q[i_insn.rd]  <= next_tag_q;
            end
            // Tags keep counting across a flush
            if (accept) begin
                next_tag_q <= next_tag_q + 1'b1;
            end
        end
    end

    // Read port for the register file, values only
    assign o_rd_data = reg_val_q[i_rd_addr];

    // A broadcast of the next tag to hand out means live tags have wrapped
    a_no_tag_wrap: assert property (
        @(posedge clk) disable iff (!n_rst) i_cdb.valid |-> (i_cdb.tag != next_tag_q)
    ) else $error("CDB carries the tag about to be allocated");

endmodule

`default_nettype wire

//--- verilog/ooo_core.sv
// Top of the issue slice with dispatch, station and ALU in a loop on the CDB
// Minimum latency from the accepting edge to the CDB pulse is 2 cycles
// i_hold blocks issue only, dispatch continues until the station fills
`default_nettype none

`include "ooo_params.svh"

module ooo_core (
    input  wire                 clk,
    input  wire                 n_rst,
    input  wire                 i_flush,
    input  wire                 i_hold,
    input  wire                 i_insn_valid,
    input  ooo_pkg::insn_t      i_insn,
    input  ooo_pkg::reg_idx_t   i_rd_addr,
    output logic                o_stall,
    output ooo_pkg::cdb_t       o_cdb,
    output ooo_pkg::data_t      o_rd_data
);

    logic                disp_valid;
    ooo_pkg::rs_entry_t  disp;
    logic                rs_full;
    logic                issue_valid;
    ooo_pkg::issue_t     issue;
    ooo_pkg::cdb_t       cdb;

    dispatch_unit u_dispatch (
        .clk          (clk),
        .n_rst        (n_rst),
        .i_flush      (i_flush),
        .i_insn_valid (i_insn_valid),
        .i_insn       (i_insn),
        .i_full       (rs_full),
        .i_cdb        (cdb),
        .i_rd_addr    (i_rd_addr),
        .o_stall      (o_stall),
        .o_disp_valid (disp_valid),
        .o_disp       (disp),
        .o_rd_data    (o_rd_data)
    );

    reservation_station #(
        .RS_DEPTH (`OOO_RS_DEPTH)
    ) u_rs (
        .clk           (clk),
        .n_rst         (n_rst),
        .i_flush       (i_flush),
        .i_disp_valid  (disp_valid),
        .i_disp        (disp),
        .i_cdb         (cdb),
        .i_fu_hold     (i_hold),
        .o_full        (rs_full),
        .o_issue_valid (issue_valid),
        .o_issue       (issue)
    );

    alu_unit u_alu (
        .clk           (clk),
        .n_rst         (n_rst),
        .i_flush       (i_flush),
        .i_issue_valid (issue_valid),
        .i_issue       (issue),
        .o_cdb         (cdb)
    );

    // The same broadcast the internal blocks see
    assign o_cdb = cdb;

endmodule

`default_nettype wire

//--- verilog/ooo_pkg.sv
// Types that travel between the dispatch unit, the station and the ALU
// Widths come from the shared parameter header
`default_nettype none

`include "ooo_params.svh"

package ooo_pkg;

    // Plain vectors with a meaning of their own
    typedef logic [`OOO_DATA_W-1:0]            data_t;
    typedef logic [`OOO_TAG_W-1:0]             tag_t;
    typedef logic [$clog2(`OOO_NUM_REGS)-1:0]  reg_idx_t;

    // Integer operations, SLL shifts by the low 5 bits of source b
    typedef enum logic [2:0] {
        OP_ADD = 3'd0,
        OP_SUB = 3'd1,
        OP_AND = 3'd2,
        OP_OR  = 3'd3,
        OP_XOR = 3'd4,
        OP_SLL = 3'd5
    } opcode_t;

    // Incoming instruction in program order
    typedef struct packed {
        opcode_t  opcode;
        reg_idx_t rd;
        reg_idx_t rs1;
        reg_idx_t rs2;
    } insn_t;

    // One source operand, either ready with data or waiting on a tag
    typedef struct packed {
        tag_t  tag;
        data_t data;
        logic  ready;
    } src_t;

    // Entry handed from dispatch to the station, index 0 is source a
    typedef struct packed {
        opcode_t        opcode;
        src_t [1:0]     src;
        tag_t           dst_tag;
    } rs_entry_t;

    // Operation handed from the station to the ALU
    typedef struct packed {
        opcode_t opcode;
        data_t   src_a;
        data_t   src_b;
        tag_t    dst_tag;
    } issue_t;

    // Result broadcast on the common data bus
    typedef struct packed {
        logic  valid;
        tag_t  tag;
        data_t data;
    } cdb_t;

endpackage

`default_nettype wire

//--- verilog/reservation_station.sv
// Age-matrix reservation station that issues the oldest ready entry
// RS_DEPTH must be a power of two from 2 to 16 and below the tag count
// Issue is combinational from slot state and is blocked by i_fu_hold
`default_nettype none

`include "ooo_params.svh"

module reservation_station #(
    parameter int RS_DEPTH = `OOO_RS_DEPTH
) (
    input  wire                 clk,
    input  wire                 n_rst,
    input  wire                 i_flush,
    input  wire                 i_disp_valid,
    input  ooo_pkg::rs_entry_t  i_disp,
    input  ooo_pkg::cdb_t       i_cdb,
    input  wire                 i_fu_hold,
    output logic                o_full,
    output logic                o_issue_valid,
    output ooo_pkg::issue_t     o_issue
);

    localparam int SLOT_W = $clog2(RS_DEPTH);

    // Per-slot state, the entry itself has no reset
    ooo_pkg::rs_entry_t      slot_q  [RS_DEPTH];
    logic [SLOT_W-1:0]       age_q   [RS_DEPTH];
    logic [RS_DEPTH-1:0]     empty_q;

    // older[i][j] is set when slot i is older than slot j
    logic [RS_DEPTH-1:0]     older   [RS_DEPTH];
    logic [RS_DEPTH-1:0]     ready;
    logic [RS_DEPTH-1:0]     issue_sel;
    logic [RS_DEPTH-1:0]     disp_sel;
    logic [SLOT_W-1:0]       issue_slot;
    logic [SLOT_W-1:0]       issue_age;
    logic                    dispatching;
    logic                    issuing;
    logic                    age_clash;

    // Age matrix and ready vector
    always_comb begin
        for (int i = 0; i < RS_DEPTH; i++) begin
            ready[i] = !empty_q[i] && slot_q[i].src[0].ready && slot_q[i].src[1].ready;
            for (int j = 0; j < RS_DEPTH; j++) begin
                older[i][j] = (i == j) ? 1'b1 : (age_q[i] > age_q[j]);
            end
        end
    end

    // A ready slot wins when it is older than every other ready slot
    // Columns of slots that are not ready are masked to one
    always_comb begin
        for (int i = 0; i < RS_DEPTH; i++) begin
            issue_sel[i] = ready[i] && (&(older[i] | ~ready));
        end
    end

    // Lowest empty slot takes the next dispatched entry
    assign disp_sel    = empty_q & ~(empty_q - 1'b1);
    assign o_full      = ~|empty_q;
    assign dispatching = i_disp_valid && !o_full;
    assign issuing     = (|issue_sel) && !i_fu_hold;

    // One-hot selection to slot index
    always_comb begin
        issue_slot = '0;
        for (int i = 0; i < RS_DEPTH; i++) begin
            if (issue_sel[i]) begin
                issue_slot = issue_slot | SLOT_W'(i);
            end
        end
    end

    assign issue_age = age_q[issue_slot];

    assign o_issue_valid   = issuing;
    assign o_issue.opcode  = slot_q[issue_slot].opcode;
    assign o_issue.src_a   = slot_q[issue_slot].src[0].data;
    assign o_issue.src_b   = slot_q[issue_slot].src[1].data;
    assign o_issue.dst_tag = slot_q[issue_slot].dst_tag;

    // Occupancy and ages
    // Dispatch alone puts the new entry at age 0 and ages everything else
    // Issue alone closes the gap above the issuing age
    // Both together only age the slots younger than the issuing one
    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            empty_q <= '1;
            for (int i = 0; i < RS_DEPTH; i++) begin
                age_q[i] <= '0;
            end
        end else begin
            for (int i = 0; i < RS_DEPTH; i++) begin
                if (i_flush) begin
                    empty_q[i] <= 1'b1;
                end else if (issuing && issue_sel[i]) begin
                    empty_q[i] <= 1'b1;
                end else if (dispatching && disp_sel[i]) begin
                    empty_q[i] <= 1'b0;
                end

                if (dispatching && disp_sel[i]) begin
                    age_q[i] <= '0;
                end else if (dispatching && issuing) begin
                    if (age_q[i] < issue_age) begin
                        age_q[i] <= age_q[i] + 1'b1;
                    end
                end else if (dispatching) begin
                    age_q[i] <= age_q[i] + 1'b1;
                end else if (issuing && (age_q[i] > issue_age)) begin
                    age_q[i] <= age_q[i] - 1'b1;
                end
            end
        end
    end

    // Entry capture and operand wakeup
    // A source that is already ready ignores the bus, its tag may be reused
    always_ff @(posedge clk) begin
        for (int i = 0; i < RS_DEPTH; i++) begin
            if (dispatching && disp_sel[i]) begin
                slot_q[i] <= i_disp;
            end else begin
                for (int k = 0; k < 2; k++) begin
                    if (!slot_q[i].src[k].ready && i_cdb.valid &&
                        (i_cdb.tag == slot_q[i].src[k].tag)) begin
                        slot_q[i].src[k].data  <= i_cdb.data;
                        slot_q[i].src[k].ready <= 1'b1;
                    end
                end
            end
        end
    end

    // Any two occupied slots sharing an age
    always_comb begin
        age_clash = 1'b0;
        for (int i = 0; i < RS_DEPTH; i++) begin
            for (int j = i + 1; j < RS_DEPTH; j++) begin
                if (!empty_q[i] && !empty_q[j] && (age_q[i] == age_q[j])) begin
                    age_clash = 1'b1;
                end
            end
        end
    end

    // The picker relies on distinct ages to yield at most one winner
    a_issue_onehot: assert property (
        @(posedge clk) disable iff (!n_rst) $onehot0(issue_sel)
    ) else $error("more than one slot selected for issue");

    a_ages_distinct: assert property (
        @(posedge clk) disable iff (!n_rst) !age_clash
    ) else $error("two occupied slots share an age");

endmodule

`default_nettype wire
